// ==== free_list.sv ====
`timescale 1ns/1ps

module free_list (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  alloc,
    input  logic                  freed_valid,
    input  rename_pkg::phys_reg_t freed_reg,
    input  logic                  walk_free,
    input  rename_pkg::phys_reg_t walk_index,
    output rename_pkg::phys_reg_t free_head,
    output logic                  free_empty
);

    // Queue storage, one slot per physical register
    rename_pkg::phys_reg_t entries [rename_pkg::PHYS_REGS];

    // Pointers wrap at PHYS_REGS, same width as a register index
    rename_pkg::phys_reg_t head_ptr;
    rename_pkg::phys_reg_t tail_ptr;
    rename_pkg::free_count_t count;

    logic                  push;
    logic                  pop;
    rename_pkg::phys_reg_t push_reg;

    // Walk and retire never push in the same cycle
    assign push     = walk_free || freed_valid;
    assign push_reg = walk_free ? walk_index : freed_reg;
    assign pop      = alloc;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail_ptr] <= push_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    // Push and pop in one cycle leave the count unchanged
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count <= '0;
        end else begin
            count <= count + rename_pkg::free_count_t'(push)
                           - rename_pkg::free_count_t'(pop);
        end
    end

    assign free_head  = entries[head_ptr];
    assign free_empty = (count == '0);

endmodule

// ==== phys_reg_walker.sv ====
`timescale 1ns/1ps

module phys_reg_walker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rebuilding,
    output logic                  walk_valid,
    output rename_pkg::phys_reg_t walk_index,
    output logic                  walk_done
);

    localparam rename_pkg::phys_reg_t LAST_INDEX =
        rename_pkg::phys_reg_t'(rename_pkg::PHYS_REGS - 1);

    rename_pkg::phys_reg_t index_q;

    // Held at zero outside a rebuild, so every walk starts from 0
    always_ff @(posedge clk) begin
        if (rst || !rebuilding) begin
            index_q <= '0;
        end else begin
            index_q <= index_q + 1'b1;
        end
    end

    assign walk_valid = rebuilding;
    assign walk_index = index_q;

    // Last register of the walk
    assign walk_done = rebuilding && (index_q == LAST_INDEX);

endmodule

// ==== rat.sv ====
`timescale 1ns/1ps

module rat (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  rename_pkg::arch_reg_t arch_rs1,
    input  rename_pkg::arch_reg_t arch_rs2,
    input  rename_pkg::arch_reg_t arch_rd,
    input  logic                  alloc,
    input  rename_pkg::phys_reg_t free_head,
    input  rename_pkg::phys_reg_t retired_map [rename_pkg::ARCH_REGS],
    output rename_pkg::phys_reg_t phys_rs1,
    output rename_pkg::phys_reg_t phys_rs2
);

    // Speculative map, newest mapping for every architectural register
    rename_pkg::phys_reg_t spec_map [rename_pkg::ARCH_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping out of reset
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                spec_map[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (flush) begin
            // Roll back to the committed state
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                spec_map[i] <= retired_map[i];
            end
        end else if (alloc) begin
            // alloc is never raised for x0, so entry 0 keeps phys 0
            spec_map[arch_rd] <= free_head;
        end
    end

    // Source lookups are combinational, same cycle as the rename
    assign phys_rs1 = spec_map[arch_rs1];
    assign phys_rs2 = spec_map[arch_rs2];

endmodule

// ==== rename_control.sv ====
`timescale 1ns/1ps

module rename_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  walk_done,
    input  logic                  rename_valid,
    input  logic                  has_rd,
    input  rename_pkg::arch_reg_t arch_rd,
    input  logic                  free_empty,
    input  logic                  retire_valid,
    output logic                  rebuilding,
    output logic                  rename_ready,
    output logic                  alloc,
    output logic                  retire_en
);

    rename_pkg::rename_state_t state;
    rename_pkg::rename_state_t state_next;
    logic                      running;
    logic                      needs_reg;

    // Flush takes priority over the end of a walk
    always_comb begin
        state_next = state;
        if (flush) begin
            state_next = rename_pkg::ST_REBUILD;
        end else if (state == rename_pkg::ST_REBUILD && walk_done) begin
            state_next = rename_pkg::ST_RUN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rename_pkg::ST_REBUILD;
        end else begin
            state <= state_next;
        end
    end

    assign running = (state == rename_pkg::ST_RUN);

    // Writes to x0 never take a register
    assign needs_reg = has_rd && (arch_rd != '0);

    // Dropped for one cycle on flush so the walker restarts at index 0
    assign rebuilding = (state == rename_pkg::ST_REBUILD) && !flush;

    assign rename_ready = running && (!needs_reg || !free_empty);
    assign alloc        = rename_valid && rename_ready && needs_reg;
    assign retire_en    = retire_valid && running;

endmodule

// ==== rename_pkg.sv ====
package rename_pkg;

    // Register file sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // Architectural register index
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

    // Physical register index
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;

    // Free list occupancy, one extra bit to reach PHYS_REGS
    typedef logic [$clog2(PHYS_REGS):0] free_count_t;

    // Rename FSM
    typedef enum logic {
        ST_REBUILD,
        ST_RUN
    } rename_state_t;

endpackage

// ==== rename_unit.f ====
rename_pkg.sv
rename_control.sv
phys_reg_walker.sv
rat.sv
retired_rat.sv
free_list.sv
rename_unit.sv
tb_rename_unit.sv

// ==== rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit (
    input  logic                  clk,
    input  logic                  rst,

    // Rename
    input  logic                  rename_valid,
    input  logic                  has_rd,
    input  rename_pkg::arch_reg_t arch_rd,
    input  rename_pkg::arch_reg_t arch_rs1,
    input  rename_pkg::arch_reg_t arch_rs2,
    output logic                  rename_ready,
    output rename_pkg::phys_reg_t phys_rs1,
    output rename_pkg::phys_reg_t phys_rs2,
    output rename_pkg::phys_reg_t phys_rd,

    // Retire
    input  logic                  retire_valid,
    input  rename_pkg::arch_reg_t retire_arch_rd,
    input  rename_pkg::phys_reg_t retire_phys_rd,

    input  logic                  flush
);

    logic                  rebuilding;
    logic                  alloc;
    logic                  retire_en;

    logic                  walk_valid;
    rename_pkg::phys_reg_t walk_index;
    logic                  walk_done;
    logic                  walk_free;

    rename_pkg::phys_reg_t retired_map [rename_pkg::ARCH_REGS];
    logic                  freed_valid;
    rename_pkg::phys_reg_t freed_reg;

    rename_pkg::phys_reg_t free_head;
    logic                  free_empty;

    rename_control u_control (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .walk_done    (walk_done),
        .rename_valid (rename_valid),
        .has_rd       (has_rd),
        .arch_rd      (arch_rd),
        .free_empty   (free_empty),
        .retire_valid (retire_valid),
        .rebuilding   (rebuilding),
        .rename_ready (rename_ready),
        .alloc        (alloc),
        .retire_en    (retire_en)
    );

    phys_reg_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .rebuilding (rebuilding),
        .walk_valid (walk_valid),
        .walk_index (walk_index),
        .walk_done  (walk_done)
    );

    rat u_rat (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .arch_rs1    (arch_rs1),
        .arch_rs2    (arch_rs2),
        .arch_rd     (arch_rd),
        .alloc       (alloc),
        .free_head   (free_head),
        .retired_map (retired_map),
        .phys_rs1    (phys_rs1),
        .phys_rs2    (phys_rs2)
    );

    retired_rat u_retired_rat (
        .clk            (clk),
        .rst            (rst),
        .retire_en      (retire_en),
        .retire_arch_rd (retire_arch_rd),
        .retire_phys_rd (retire_phys_rd),
        .walk_valid     (walk_valid),
        .walk_index     (walk_index),
        .retired_map    (retired_map),
        .freed_valid    (freed_valid),
        .freed_reg      (freed_reg),
        .walk_free      (walk_free)
    );

    free_list u_free_list (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .alloc       (alloc),
        .freed_valid (freed_valid),
        .freed_reg   (freed_reg),
        .walk_free   (walk_free),
        .walk_index  (walk_index),
        .free_head   (free_head),
        .free_empty  (free_empty)
    );

    // No destination register means phys 0
    assign phys_rd = alloc ? free_head : '0;

endmodule

// ==== retired_rat.sv ====
`timescale 1ns/1ps

module retired_rat (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  retire_en,
    input  rename_pkg::arch_reg_t retire_arch_rd,
    input  rename_pkg::phys_reg_t retire_phys_rd,
    input  logic                  walk_valid,
    input  rename_pkg::phys_reg_t walk_index,
    output rename_pkg::phys_reg_t retired_map [rename_pkg::ARCH_REGS],
    output logic                  freed_valid,
    output rename_pkg::phys_reg_t freed_reg,
    output logic                  walk_free
);

    // Committed map
    rename_pkg::phys_reg_t commit_map [rename_pkg::ARCH_REGS];

    // One bit per physical register held by the committed map
    logic [rename_pkg::PHYS_REGS-1:0] held;

    rename_pkg::phys_reg_t old_reg;

    // Mapping being replaced by this retire
    assign old_reg = commit_map[retire_arch_rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                commit_map[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (retire_en) begin
            commit_map[retire_arch_rd] <= retire_phys_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map holds the low ARCH_REGS registers
            for (int i = 0; i < rename_pkg::PHYS_REGS; i++) begin
                held[i] <= (i < rename_pkg::ARCH_REGS);
            end
        end else if (retire_en) begin
            // New bit written last, so it survives if old and new match
            held[old_reg]        <= 1'b0;
            held[retire_phys_rd] <= 1'b1;
        end
    end

    // Whole table for a flush restore
    always_comb begin
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            retired_map[i] = commit_map[i];
        end
    end

    // The released register goes back to the free list at the same edge
    assign freed_valid = retire_en;
    assign freed_reg   = old_reg;

    // Walk keeps every register the committed map does not hold
    assign walk_free = walk_valid && !held[walk_index];

endmodule

// ==== tb_rename_unit.sv ====
`timescale 1ns/1ps

module tb_rename_unit;

    localparam int RESET_CYCLES  = 16;
    localparam int READY_LIMIT   = 100;
    localparam int ACCEPT_LIMIT  = 200;
    localparam int RANDOM_CYCLES = 3000;

    logic                  clk;
    logic                  rst;
    logic                  rename_valid;
    logic                  has_rd;
    rename_pkg::arch_reg_t arch_rd;
    rename_pkg::arch_reg_t arch_rs1;
    rename_pkg::arch_reg_t arch_rs2;
    logic                  rename_ready;
    rename_pkg::phys_reg_t phys_rs1;
    rename_pkg::phys_reg_t phys_rs2;
    rename_pkg::phys_reg_t phys_rd;
    logic                  retire_valid;
    rename_pkg::arch_reg_t retire_arch_rd;
    rename_pkg::phys_reg_t retire_phys_rd;
    logic                  flush;

    // Reference model state
    int spec_model [rename_pkg::ARCH_REGS];
    int ret_model  [rename_pkg::ARCH_REGS];
    int free_model [$];
    int flight_arch [$];
    int flight_phys [$];
    bit model_running;
    int model_walk;

    int errors   = 0;
    int timeouts = 0;
    bit fired    = 1'b0;
    int fired_rd = 0;

    rename_unit DUT (
        .clk            (clk),
        .rst            (rst),
        .rename_valid   (rename_valid),
        .has_rd         (has_rd),
        .arch_rd        (arch_rd),
        .arch_rs1       (arch_rs1),
        .arch_rs2       (arch_rs2),
        .rename_ready   (rename_ready),
        .phys_rs1       (phys_rs1),
        .phys_rs2       (phys_rs2),
        .phys_rd        (phys_rd),
        .retire_valid   (retire_valid),
        .retire_arch_rd (retire_arch_rd),
        .retire_phys_rd (retire_phys_rd),
        .flush          (flush)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic bit held_by_retired(int p);
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            if (ret_model[i] == p) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Expected outputs for the inputs now on the pins
    function automatic void expected_outputs(output bit exp_ready, output int exp_rs1,
                                             output int exp_rs2, output int exp_rd);
        bit needs;
        needs     = has_rd && (arch_rd != 0);
        exp_ready = model_running && (!needs || free_model.size() > 0);
        exp_rs1   = spec_model[arch_rs1];
        exp_rs2   = spec_model[arch_rs2];
        exp_rd    = (rename_valid && exp_ready && needs) ? free_model[0] : 0;
    endfunction

    // Model state change at a rising edge
    function automatic void advance_model(bit fire);
        int new_reg;
        int old_reg;
        if (rst || flush) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                spec_model[i] = rst ? i : ret_model[i];
                if (rst) begin
                    ret_model[i] = i;
                end
            end
            free_model.delete();
            flight_arch.delete();
            flight_phys.delete();
            model_running = 1'b0;
            model_walk    = 0;
        end else if (!model_running) begin
            // Rebuild keeps every register outside the retired map
            if (!held_by_retired(model_walk)) begin
                free_model.push_back(model_walk);
            end
            if (model_walk == rename_pkg::PHYS_REGS - 1) begin
                model_running = 1'b1;
            end else begin
                model_walk++;
            end
        end else begin
            if (fire) begin
                new_reg = free_model.pop_front();
                spec_model[arch_rd] = new_reg;
                flight_arch.push_back(arch_rd);
                flight_phys.push_back(new_reg);
            end
            if (retire_valid) begin
                old_reg = ret_model[retire_arch_rd];
                ret_model[retire_arch_rd] = retire_phys_rd;
                free_model.push_back(old_reg);
                void'(flight_arch.pop_front());
                void'(flight_phys.pop_front());
            end
        end
    endfunction

    task automatic report_mismatch(string name, int expected, int actual);
        errors++;
        $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic finish_run;
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // Compare at every rising edge, before the DUT registers move
    initial begin
        bit exp_ready;
        int exp_rs1;
        int exp_rs2;
        int exp_rd;
        forever begin
            @(posedge clk);
            expected_outputs(exp_ready, exp_rs1, exp_rs2, exp_rd);
            if (!rst) begin
                if (rename_ready !== exp_ready) begin
                    report_mismatch("rename_ready", exp_ready, rename_ready);
                end
                if (phys_rs1 !== exp_rs1) begin
                    report_mismatch("phys_rs1", exp_rs1, phys_rs1);
                end
                if (phys_rs2 !== exp_rs2) begin
                    report_mismatch("phys_rs2", exp_rs2, phys_rs2);
                end
                if (phys_rd !== exp_rd) begin
                    report_mismatch("phys_rd", exp_rd, phys_rd);
                end
            end
            fired    = rename_valid && rename_ready;
            fired_rd = phys_rd;
            advance_model(rename_valid && exp_ready && has_rd && (arch_rd != 0));
        end
    end

    task automatic drive_idle;
        rename_valid   = 1'b0;
        has_rd         = 1'b0;
        arch_rd        = '0;
        arch_rs1       = '0;
        arch_rs2       = '0;
        retire_valid   = 1'b0;
        retire_arch_rd = '0;
        retire_phys_rd = '0;
        flush          = 1'b0;
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic rename_one(bit has, int rd, int rs1, int rs2, output int got);
        int waited;
        rename_valid = 1'b1;
        has_rd       = has;
        arch_rd      = rename_pkg::arch_reg_t'(rd);
        arch_rs1     = rename_pkg::arch_reg_t'(rs1);
        arch_rs2     = rename_pkg::arch_reg_t'(rs2);
        waited       = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACCEPT_LIMIT) begin
                timeouts++;
                $display("Timeout: rename not accepted within %0d cycles", ACCEPT_LIMIT);
                finish_run();
            end
        end while (!fired);
        got          = fired_rd;
        rename_valid = 1'b0;
        has_rd       = 1'b0;
    endtask

    task automatic retire_oldest;
        retire_valid   = 1'b1;
        retire_arch_rd = rename_pkg::arch_reg_t'(flight_arch[0]);
        retire_phys_rd = rename_pkg::phys_reg_t'(flight_phys[0]);
        @(negedge clk);
        retire_valid = 1'b0;
    endtask

    task automatic wait_ready(int limit);
        int waited;
        waited = 0;
        while (rename_ready !== 1'b1) begin
            if (waited >= limit) begin
                timeouts++;
                $display("Timeout: rename_ready stayed low for %0d cycles", limit);
                finish_run();
            end
            @(negedge clk);
            waited++;
        end
    endtask

    initial begin
        int got;
        int expected_q [$];
        void'($urandom(32'hbd3c4751));
        rst = 1'b1;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Free list after reset holds 32 and up
        wait_ready(READY_LIMIT);
        for (int i = 0; i < 3; i++) begin
            rename_one(1'b1, i + 1, i, 0, got);
            if (got != 32 + i) report_mismatch("phys_rd", 32 + i, got);
        end

        // No destination, nothing consumed
        rename_one(1'b0, 7, 3, 1, got);
        if (got != 0) report_mismatch("phys_rd", 0, got);
        rename_one(1'b1, 0, 2, 3, got);
        if (got != 0) report_mismatch("phys_rd", 0, got);
        rename_one(1'b1, 5, 3, 5, got);
        if (got != 35) report_mismatch("phys_rd", 35, got);

        // Drain the rest of the free list
        for (int i = 0; i < 28; i++) begin
            rename_one(1'b1, (i % 31) + 1, i % 32, (i + 7) % 32, got);
        end
        has_rd  = 1'b1;
        arch_rd = 5'd9;
        @(negedge clk);
        if (rename_ready !== 1'b0) report_mismatch("rename_ready", 0, rename_ready);
        has_rd = 1'b0;
        @(negedge clk);
        if (rename_ready !== 1'b1) report_mismatch("rename_ready", 1, rename_ready);
        drive_idle();

        // Retired registers come back in FIFO order
        retire_oldest();
        retire_oldest();
        retire_oldest();
        rename_one(1'b1, 4, 1, 2, got);
        if (got != 1) report_mismatch("phys_rd", 1, got);

        // Register freed now queues behind 2 and 3
        retire_oldest();
        rename_one(1'b1, 6, 4, 0, got);
        if (got != 2) report_mismatch("phys_rd", 2, got);
        rename_one(1'b1, 7, 5, 3, got);
        if (got != 3) report_mismatch("phys_rd", 3, got);
        rename_one(1'b1, 8, 0, 0, got);
        if (got != 5) report_mismatch("phys_rd", 5, got);

        // Flush and rebuild from the retired map
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        if (rename_ready !== 1'b0) report_mismatch("rename_ready", 0, rename_ready);
        wait_ready(READY_LIMIT);
        for (int p = 0; p < rename_pkg::PHYS_REGS; p++) begin
            if (!held_by_retired(p)) expected_q.push_back(p);
        end
        for (int i = 0; i < 3; i++) begin
            rename_one(1'b1, 10 + i, i + 1, 2, got);
            if (got != expected_q[i]) report_mismatch("phys_rd", expected_q[i], got);
        end

        // Random mix, inputs held while not accepted
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            if (!rename_valid || fired) begin
                rename_valid = ($urandom % 4) != 0;
                has_rd       = ($urandom % 8) != 0;
                arch_rd      = rename_pkg::arch_reg_t'($urandom % rename_pkg::ARCH_REGS);
                arch_rs1     = rename_pkg::arch_reg_t'($urandom % rename_pkg::ARCH_REGS);
                arch_rs2     = rename_pkg::arch_reg_t'($urandom % rename_pkg::ARCH_REGS);
            end
            retire_valid = 1'b0;
            flush        = 1'b0;
            if (flight_arch.size() > 0 && ($urandom % 3) == 0) begin
                retire_valid   = 1'b1;
                retire_arch_rd = rename_pkg::arch_reg_t'(flight_arch[0]);
                retire_phys_rd = rename_pkg::phys_reg_t'(flight_phys[0]);
            end else if (($urandom % 200) == 0) begin
                // Pending instruction is squashed by the flush
                flush        = 1'b1;
                rename_valid = 1'b0;
            end
            @(negedge clk);
        end
        drive_idle();
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule
